// ==== run_sim.sh ====
#!/bin/sh
# builds the switch testbench with Verilator, runs it and judges the log

LOG=sim.log
BIN=switch_sim

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module switch_tb -o "$BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "RESULT: FAIL (build status $build_status)"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "RESULT: FAIL (simulation status $run_status)"
    exit 1
fi

echo "RESULT: PASS"
exit 0

// ==== sim.f ====
+incdir+testbench
verilog/eth_frame_pkg.sv
verilog/switch_cfg_pkg.sv
verilog/nibble_rx.sv
verilog/ingress_buffer.sv
verilog/fdb_table.sv
verilog/egress_port.sv
verilog/switch_top.sv
testbench/switch_tb.sv

// ==== testbench/switch_model.svh ====
// switch reference model: learned MAC table, expected frames per input and output, tx capture
`ifndef SWITCH_MODEL_SVH
`define SWITCH_MODEL_SVH

typedef struct packed {
   logic [15:0]                  tag;    // unique per frame, also in bytes 12 and 13
   logic [7:0]                   len;
   logic [FRAME_MAX_BYTES*8-1:0] data;   // byte k at bits 8k+7 down to 8k
} frame_t;

port_idx_t fdb_model [mac_addr_t];
frame_t    exp_q [N_PORTS][N_PORTS][$];  // indexed by input, then output

function automatic mac_addr_t frame_mac(input frame_t f, input int ofs);
   mac_addr_t m;
   m = '0;
   for (int k = 0; k < 6; k++)
      m = {m[39:0], f.data[8*(ofs+k) +: 8]};   // MSB first on the wire
   return m;
endfunction

// lookup against the old table, then learn the source
function automatic void model_ingress(input port_idx_t in_port, input frame_t f);
   mac_addr_t dst;
   mac_addr_t src;
   if (f.len < HDR_BYTES || f.len > FRAME_MAX_BYTES)
      return;   // runts never reach the table
   dst = frame_mac(f, DST_OFS);
   src = frame_mac(f, SRC_OFS);
   if (fdb_model.exists(dst) && fdb_model[dst] != in_port)
      exp_q[in_port][fdb_model[dst]].push_back(f);
   fdb_model[src] = in_port;
endfunction

function automatic int frames_pending();
   int n;
   n = 0;
   for (int i = 0; i < N_PORTS; i++)
      for (int o = 0; o < N_PORTS; o++)
         n += exp_q[i][o].size();
   return n;
endfunction

// frame must be the oldest one expected from some input on this output
task automatic match_frame(input int o, input frame_t got);
   frame_t exp;
   int     src_in;
   src_in = -1;
   for (int i = N_PORTS - 1; i >= 0; i--)
      if (exp_q[i][o].size() > 0 && exp_q[i][o][0].tag == got.tag)
         src_in = i;
   if (src_in < 0)
      stop_on_error($sformatf("output %0d sent a frame that was not expected (tag %04h)",
                              o, got.tag));
   else
   begin
      exp = exp_q[src_in][o].pop_front();
      check_frame_len(port_idx_t'(o), int'(got.len), int'(exp.len));
      for (int k = 0; k < int'(exp.len); k++)
         check_byte(got.data[8*k +: 8], exp.data[8*k +: 8],
                    $sformatf("output %0d tag %04h byte %0d", o, exp.tag, k));
   end
endtask

// rebuilds frames from one tx lane, low nibble first
task automatic capture_lane(input int o);
   frame_t     got;
   int         nib;
   logic [3:0] lo;
   forever
   begin
      got = '0;
      nib = 0;
      @(negedge clk);
      while (tx[o].en !== 1'b1)
         @(negedge clk);
      while (tx[o].en === 1'b1)
      begin
         if (nib % 2 == 0)
            lo = tx[o].nibble;
         else
            got.data[8*(nib/2) +: 8] = {tx[o].nibble, lo};
         nib++;
         if (nib > 2 * FRAME_MAX_BYTES)
            stop_on_error($sformatf("output %0d sent a frame longer than %0d bytes",
                                    o, FRAME_MAX_BYTES));
         @(negedge clk);
      end
      if (nib % 2 != 0 || nib < 2 * HDR_BYTES)
         stop_on_error($sformatf("output %0d sent a broken frame of %0d nibbles", o, nib));
      else
      begin
         got.len = 8'(nib / 2);
         got.tag = {got.data[8*12 +: 8], got.data[8*13 +: 8]};
         match_frame(o, got);
      end
   end
endtask

`endif

// ==== testbench/switch_tb.sv ====
// testbench for the six-port switch: random traffic checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module switch_tb;

   import switch_cfg_pkg::*;
   import eth_frame_pkg::*;

   localparam int SEED      = 78677;
   localparam int GAP       = 816;     // input buffer is free again after this
   localparam int RST_CYC   = 4;
   localparam int DRAIN_MAX = 4000;
   localparam int RUN_MAX   = 200000;
   localparam int N_HOSTS   = 2 * N_PORTS;

   logic                   clk;
   logic                   rst_n;
   line_rx_t [N_PORTS-1:0] rx;
   line_tx_t [N_PORTS-1:0] tx;
   mac_addr_t              host_mac [N_HOSTS];
   port_idx_t              home [N_HOSTS];   // port each host sends from
   logic [15:0]            next_tag;
   int                     active;           // senders still running

   `include "switch_model.svh"

   switch_top UUT (.clk(clk), .rst_n_i(rst_n), .rx_i(rx), .tx_o(tx));

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("CHECK FAILED at %0t: %s is %02h, expected %02h",
                                 $time, what, got, exp));
   endtask

   task automatic check_frame_len(input port_idx_t port, input int got, input int exp);
      if (got != exp)
         stop_on_error($sformatf("CHECK FAILED at %0t: frame on output %0d has %0d bytes, expected %0d",
                                 $time, port, got, exp));
   endtask

   function automatic int rand_len();
      return HDR_BYTES + int'($urandom_range(FRAME_MAX_BYTES - HDR_BYTES));
   endfunction

   // random host that currently sends from port p
   function automatic int host_on(input int p);
      int cand [$];
      for (int h = 0; h < N_HOSTS; h++)
         if (home[h] == port_idx_t'(p))
            cand.push_back(h);
      return cand[$urandom_range(cand.size() - 1)];
   endfunction

   function automatic int host_off(input int p);
      int h;
      h = $urandom_range(N_HOSTS - 1);
      while (home[h] == port_idx_t'(p))
         h = (h + 1) % N_HOSTS;
      return h;
   endfunction

   function automatic frame_t build_frame(input mac_addr_t dst, input mac_addr_t src,
                                          input int len);
      frame_t f;
      f = '0;
      f.len = 8'(len);
      f.tag = next_tag;
      next_tag = next_tag + 1'b1;
      for (int k = 0; k < len; k++)
         f.data[8*k +: 8] = 8'($urandom);
      for (int k = 0; k < 6; k++)
      begin
         f.data[8*(DST_OFS+k) +: 8] = dst[47-8*k -: 8];
         f.data[8*(SRC_OFS+k) +: 8] = src[47-8*k -: 8];
      end
      f.data[8*12 +: 8] = f.tag[15:8];
      f.data[8*13 +: 8] = f.tag[7:0];
      return f;
   endfunction

   // one dv burst, then the gap the input buffer needs
   task automatic send_frame(input int p, input frame_t f);
      logic [7:0] b;
      for (int k = 0; k < int'(f.len); k++)
      begin
         b = f.data[8*k +: 8];
         @(posedge clk);
         #2 rx[p] = '{dv: 1'b1, nibble: b[3:0]};
         @(posedge clk);
         #2 rx[p] = '{dv: 1'b1, nibble: b[7:4]};
      end
      @(posedge clk);
      #2 rx[p] = '0;
      model_ingress(port_idx_t'(p), f);
      repeat (GAP) @(posedge clk);
   endtask

   // background sender, dst or len below zero means random
   task automatic start_stream(input int p, input int n_frames, input int dst, input int len);
      active++;
      fork
         begin
            frame_t f;
            int     d;
            for (int n = 0; n < n_frames; n++)
            begin
               d = (dst < 0) ? int'($urandom_range(N_HOSTS - 1)) : dst;
               f = build_frame(host_mac[d], host_mac[host_on(p)], (len < 0) ? rand_len() : len);
               send_frame(p, f);
            end
            active--;
         end
      join_none
   endtask

   task automatic wait_senders(input int limit);
      int t;
      t = 0;
      while (active != 0 && t < limit)
      begin
         @(posedge clk);
         t++;
      end
      if (active != 0)
         stop_on_error("senders did not finish in time");
   endtask

   task automatic wait_drained(input string phase);
      int t;
      t = 0;
      while (frames_pending() != 0 && t < DRAIN_MAX)
      begin
         @(posedge clk);
         t++;
      end
      if (frames_pending() != 0)
         stop_on_error($sformatf("%s: %0d expected frames never left the switch",
                                 phase, frames_pending()));
   endtask

   function automatic logic tx_idle();
      for (int o = 0; o < N_PORTS; o++)
         if (tx[o].en !== 1'b0)
            return 1'b0;
      return 1'b1;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #10 clk = !clk;
   end

   initial
   begin
      for (int c = 0; c < RUN_MAX; c++)
         @(posedge clk);
      stop_on_error("simulation ran past its cycle limit");
   end

   initial
   begin
      for (int o = 0; o < N_PORTS; o++)
      begin
         automatic int lane = o;
         fork
            capture_lane(lane);
         join_none
      end
   end

   initial
   begin
      mac_addr_t stranger;
      mac_addr_t ghost;
      int        p;
      int        h;
      int        o;
      frame_t    f;
      void'($urandom(SEED));
      rst_n    = 1'b0;
      rx       = '0;
      active   = 0;
      next_tag = 16'h0100;
      for (int k = 0; k < N_HOSTS; k++)
      begin
         host_mac[k] = {8'h02, 32'($urandom), 8'(k)};   // low byte keeps them distinct
         home[k]     = port_idx_t'(k / 2);
      end
      stranger = {8'h02, 32'($urandom), 8'hf0};
      ghost    = {8'h02, 32'($urandom), 8'hf1};
      repeat (RST_CYC) @(posedge clk);
      #2 rst_n = 1'b1;

      // learning, every destination still unknown
      for (int k = 0; k < N_HOSTS; k++)
      begin
         f = build_frame((k < N_HOSTS - 1) ? host_mac[k+1] : stranger, host_mac[k], rand_len());
         send_frame(home[k], f);
      end
      wait_drained("learning");

      // known unicast
      for (int n = 0; n < 8; n++)
      begin
         p = $urandom_range(N_PORTS - 1);
         f = build_frame(host_mac[host_off(p)], host_mac[host_on(p)], rand_len());
         send_frame(p, f);
      end
      wait_drained("known unicast");

      // five inputs to one output at once
      o = $urandom_range(N_PORTS - 1);
      h = host_on(o);
      for (int q = 0; q < N_PORTS; q++)
         if (q != o)
            start_stream(q, 1, h, FRAME_MAX_BYTES);
      wait_senders(4 * GAP);
      wait_drained("contention");

      // destination on the sending port
      p = $urandom_range(N_PORTS - 1);
      send_frame(p, build_frame(host_mac[2*p+1], host_mac[2*p], rand_len()));
      wait_drained("same port");

      // runt from an unknown host, then a frame to it
      send_frame(2, build_frame(host_mac[0], ghost, 1 + int'($urandom_range(HDR_BYTES - 2))));
      send_frame(4, build_frame(ghost, host_mac[host_on(4)], rand_len()));
      wait_drained("runt");

      // host 0 moves to port 3
      send_frame(3, build_frame(host_mac[2], host_mac[0], rand_len()));
      home[0] = port_idx_t'(3);
      send_frame(1, build_frame(host_mac[0], host_mac[host_on(1)], rand_len()));
      wait_drained("relearning");

      for (int q = 0; q < N_PORTS; q++)
         start_stream(q, 5, -1, -1);
      wait_senders(10 * GAP);
      wait_drained("parallel traffic");

      if (frames_pending() == 0 && tx_idle())
      begin
         $display("No errors");
         $finish;
      end
      else
         stop_on_error("switch still transmitting at the end of the run");
   end

endmodule

`default_nettype wire

// ==== verilog/egress_port.sv ====
// egress port: round-robin arbiter, crossbar mux and nibble serializer for one output
`timescale 1ns/1ps
`default_nettype none

module egress_port
(
   input  wire                                                        clk,
   input  wire                                                        rst_n_i,
   input  wire switch_cfg_pkg::port_vec_t                             req_i,
   input  wire eth_frame_pkg::byte_strm_t [switch_cfg_pkg::N_PORTS-1:0] strm_i,
   output switch_cfg_pkg::port_vec_t                                  gnt_o,
   output eth_frame_pkg::line_tx_t                                    tx_o
);

   import switch_cfg_pkg::*;
   import eth_frame_pkg::*;

   port_idx_t  rr_q;        // last winner
   logic       busy_q;
   logic [3:0] hi_nib_q;
   logic       hi_pend_q;   // high nibble still to go
   logic       win_vld;
   port_idx_t  win;
   byte_strm_t cur;

   // search starts one past the last winner
   always_comb
   begin
      int cand;
      win_vld = 1'b0;
      win     = rr_q;
      for (int k = N_PORTS; k >= 1; k--)
      begin
         cand = (int'(rr_q) + k) % N_PORTS;
         if (req_i[cand])
         begin
            win_vld = 1'b1;
            win     = port_idx_t'(cand);
         end
      end
   end

   always_comb
   begin
      cur = '0;
      for (int p = 0; p < N_PORTS; p++)
      begin
         if (gnt_o[p])
            cur = strm_i[p];
      end
   end

   always_ff @(posedge clk)
   begin
      if (cur.valid)
         hi_nib_q <= cur.data[7:4];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         rr_q      <= port_idx_t'(N_PORTS - 1);   // first search begins at port 0
         busy_q    <= 1'b0;
         gnt_o     <= '0;
         hi_pend_q <= 1'b0;
         tx_o      <= '0;
      end
      else
      begin
         if (!busy_q && win_vld)
         begin
            busy_q <= 1'b1;
            gnt_o  <= port_vec_t'(1) << win;
            rr_q   <= win;
         end
         else if (busy_q && cur.valid && cur.eof)
         begin
            busy_q <= 1'b0;   // free for a new grant next cycle
            gnt_o  <= '0;
         end

         if (cur.valid)
         begin
            tx_o.en     <= 1'b1;
            tx_o.nibble <= cur.data[3:0];
            hi_pend_q   <= 1'b1;
         end
         else if (hi_pend_q)
         begin
            tx_o.nibble <= hi_nib_q;
            hi_pend_q   <= 1'b0;
         end
         else
            tx_o.en <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/eth_frame_pkg.sv ====
// ethernet frame definitions: MAC address, header layout, line lanes and byte stream
`default_nettype none

package eth_frame_pkg;

   typedef logic [47:0] mac_addr_t;

   localparam int HDR_BYTES        = 14;
   localparam int DST_OFS          = 0;    // destination MAC comes first
   localparam int SRC_OFS          = 6;
   localparam int NIBBLES_PER_BYTE = 2;

   // receive lane, low nibble of each byte first
   typedef struct packed {
      logic       dv;
      logic [3:0] nibble;
   } line_rx_t;

   typedef struct packed {
      logic       en;
      logic [3:0] nibble;
   } line_tx_t;

   // one byte on the internal stream
   typedef struct packed {
      logic       valid;
      logic       sof;
      logic       eof;
      logic [7:0] data;
   } byte_strm_t;

endpackage

`default_nettype wire

// ==== verilog/fdb_table.sv ====
// forwarding database: looks up destination MACs and learns source MACs for all ports
`timescale 1ns/1ps
`default_nettype none

module fdb_table
(
   input  wire                                                      clk,
   input  wire                                                      rst_n_i,
   input  wire switch_cfg_pkg::fdb_req_t [switch_cfg_pkg::N_PORTS-1:0] req_i,
   output switch_cfg_pkg::fdb_resp_t [switch_cfg_pkg::N_PORTS-1:0]      resp_o
);

   import switch_cfg_pkg::*;
   import eth_frame_pkg::*;

   logic [FDB_ENTRIES-1:0] vld_q;
   mac_addr_t              mac_q  [FDB_ENTRIES];
   port_idx_t              port_q [FDB_ENTRIES];
   logic [FDB_IDX_W-1:0]   rr_q;        // victim when the table is full
   logic                   sel_vld;
   port_idx_t              sel;
   fdb_req_t               cur;
   logic                   dst_hit;
   port_idx_t              dst_port;
   logic                   src_hit;
   logic [FDB_IDX_W-1:0]   src_idx;
   logic                   free_vld;
   logic [FDB_IDX_W-1:0]   free_idx;
   logic [FDB_IDX_W-1:0]   learn_idx;

   // lowest pending port wins, skipping one being answered this cycle
   always_comb
   begin
      sel_vld = 1'b0;
      sel     = '0;
      for (int p = N_PORTS - 1; p >= 0; p--)
      begin
         if (req_i[p].valid && !resp_o[p].done)
         begin
            sel_vld = 1'b1;
            sel     = port_idx_t'(p);
         end
      end
   end

   assign cur = req_i[sel];

   always_comb
   begin
      dst_hit  = 1'b0;
      dst_port = '0;
      src_hit  = 1'b0;
      src_idx  = '0;
      free_vld = 1'b0;
      free_idx = '0;
      for (int e = FDB_ENTRIES - 1; e >= 0; e--)
      begin
         if (vld_q[e] && mac_q[e] == cur.dst_mac)
         begin
            dst_hit  = 1'b1;
            dst_port = port_q[e];
         end
         if (vld_q[e] && mac_q[e] == cur.src_mac)
         begin
            src_hit = 1'b1;
            src_idx = FDB_IDX_W'(e);
         end
         if (!vld_q[e])
         begin
            free_vld = 1'b1;
            free_idx = FDB_IDX_W'(e);
         end
      end
   end

   assign learn_idx = src_hit ? src_idx : (free_vld ? free_idx : rr_q);

   always_ff @(posedge clk)
   begin
      if (sel_vld)
      begin
         mac_q[learn_idx]  <= cur.src_mac;
         port_q[learn_idx] <= sel;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         vld_q  <= '0;
         rr_q   <= '0;
         resp_o <= '0;
      end
      else
      begin
         resp_o <= '0;
         if (sel_vld)
         begin
            // a destination on the asking port counts as a miss
            resp_o[sel] <= '{done: 1'b1, hit: dst_hit && dst_port != sel, port: dst_port};
            vld_q[learn_idx] <= 1'b1;
            if (!src_hit && !free_vld)
               rr_q <= rr_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ingress_buffer.sv ====
// ingress buffer: stores one frame, looks up its output port and sends it once granted
`timescale 1ns/1ps
`default_nettype none

module ingress_buffer
(
   input  wire                            clk,
   input  wire                            rst_n_i,
   input  wire switch_cfg_pkg::port_idx_t port_id_i,
   input  wire eth_frame_pkg::byte_strm_t byte_i,
   output switch_cfg_pkg::fdb_req_t       fdb_req_o,
   input  wire switch_cfg_pkg::fdb_resp_t fdb_resp_i,
   output switch_cfg_pkg::port_vec_t      req_o,
   input  wire                            gnt_i,
   output eth_frame_pkg::byte_strm_t      strm_o
);

   import switch_cfg_pkg::*;
   import eth_frame_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_RX, S_LOOKUP, S_REQ, S_SEND} state_t;

   state_t                            state_q;
   logic [7:0]                        mem [FRAME_MAX_BYTES];
   logic [BUF_ADDR_W:0]               len_q;      // bytes stored so far
   logic [BUF_ADDR_W:0]               wr_pos;
   logic [BUF_ADDR_W-1:0]             rd_ptr_q;
   logic [$clog2(NIBBLES_PER_BYTE):0] pace_q;
   mac_addr_t                         dst_mac_q;
   mac_addr_t                         src_mac_q;
   port_idx_t                         dst_port_q;
   logic                              accept;
   logic                              wr_ok;
   logic                              in_dst;
   logic                              in_src;
   logic                              emit;
   logic                              last_rd;
   logic                              fwd_ok;

   // only a sof byte can open a frame, so a frame seen while busy is dropped whole
   assign accept  = byte_i.valid && ((state_q == S_IDLE && byte_i.sof) || state_q == S_RX);
   assign wr_pos  = (state_q == S_IDLE) ? '0 : len_q;
   assign wr_ok   = int'(wr_pos) < FRAME_MAX_BYTES;
   assign in_dst  = int'(wr_pos) >= DST_OFS && int'(wr_pos) < DST_OFS + $bits(mac_addr_t) / 8;
   assign in_src  = int'(wr_pos) >= SRC_OFS && int'(wr_pos) < SRC_OFS + $bits(mac_addr_t) / 8;
   assign emit    = (state_q == S_REQ && gnt_i) ||
                    (state_q == S_SEND && int'(pace_q) == NIBBLES_PER_BYTE - 1);
   assign last_rd = int'(rd_ptr_q) == int'(len_q) - 1;
   assign fwd_ok  = fdb_resp_i.hit && fdb_resp_i.port != port_id_i;

   assign fdb_req_o = '{valid: state_q == S_LOOKUP, src_mac: src_mac_q, dst_mac: dst_mac_q};
   assign req_o     = (state_q == S_REQ || state_q == S_SEND) ?
                      port_vec_t'(1) << dst_port_q : '0;

   always_ff @(posedge clk)
   begin
      if (accept && wr_ok)
      begin
         mem[wr_pos[BUF_ADDR_W-1:0]] <= byte_i.data;
         len_q <= wr_pos + 1'b1;
      end
      if (accept && in_dst)   // wire order is MSB first
         dst_mac_q <= {dst_mac_q[$bits(mac_addr_t)-9:0], byte_i.data};
      if (accept && in_src)
         src_mac_q <= {src_mac_q[$bits(mac_addr_t)-9:0], byte_i.data};
      if (state_q == S_LOOKUP && fdb_resp_i.done)
         dst_port_q <= fdb_resp_i.port;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q  <= S_IDLE;
         rd_ptr_q <= '0;
         pace_q   <= '0;
         strm_o   <= '0;
      end
      else
      begin
         strm_o.valid <= 1'b0;
         if (emit)
         begin
            strm_o   <= '{valid: 1'b1, sof: state_q == S_REQ, eof: last_rd,
                          data: mem[rd_ptr_q]};
            rd_ptr_q <= rd_ptr_q + 1'b1;
            pace_q   <= '0;
         end
         else if (state_q == S_SEND)
            pace_q <= pace_q + 1'b1;

         case (state_q)
            S_IDLE, S_RX:
               if (accept)
               begin
                  if (!byte_i.eof)
                     state_q <= S_RX;
                  else if (wr_ok && int'(wr_pos) + 1 >= HDR_BYTES)
                  begin
                     state_q  <= S_LOOKUP;
                     rd_ptr_q <= '0;
                  end
                  else
                     state_q <= S_IDLE;   // runt or overlong
               end
            S_LOOKUP:
               if (fdb_resp_i.done)
                  state_q <= fwd_ok ? S_REQ : S_IDLE;
            S_REQ:
               if (gnt_i)
                  state_q <= S_SEND;
            S_SEND:
               if (emit && last_rd)
                  state_q <= S_IDLE;
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/nibble_rx.sv ====
// nibble receiver: builds bytes from the line nibbles and marks frame start and end
`timescale 1ns/1ps
`default_nettype none

module nibble_rx
(
   input  wire                          clk,
   input  wire                          rst_n_i,
   input  wire eth_frame_pkg::line_rx_t rx_i,
   output eth_frame_pkg::byte_strm_t    byte_o
);

   logic       hi_phase_q;    // next nibble completes a byte
   logic       first_q;       // next byte opens the frame
   logic [3:0] lo_nib_q;
   logic       pend_vld_q;    // byte held back until eof is known
   logic       pend_sof_q;
   logic [7:0] pend_data_q;

   always_ff @(posedge clk)
   begin
      if (rx_i.dv && !hi_phase_q)
         lo_nib_q <= rx_i.nibble;
      if (rx_i.dv && hi_phase_q)
      begin
         pend_data_q <= {rx_i.nibble, lo_nib_q};
         pend_sof_q  <= first_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         hi_phase_q <= 1'b0;
         first_q    <= 1'b1;
         pend_vld_q <= 1'b0;
         byte_o     <= '0;
      end
      else
      begin
         byte_o.valid <= 1'b0;
         if (rx_i.dv)
         begin
            hi_phase_q <= !hi_phase_q;
            if (hi_phase_q)
            begin
               first_q    <= 1'b0;
               pend_vld_q <= 1'b1;
               if (pend_vld_q)   // release the previous byte
                  byte_o <= '{valid: 1'b1, sof: pend_sof_q, eof: 1'b0, data: pend_data_q};
            end
         end
         else
         begin
            hi_phase_q <= 1'b0;  // a stray odd nibble is lost here
            first_q    <= 1'b1;
            pend_vld_q <= 1'b0;
            if (pend_vld_q)
               byte_o <= '{valid: 1'b1, sof: pend_sof_q, eof: 1'b1, data: pend_data_q};
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/switch_cfg_pkg.sv ====
// switch configuration: port count, table and buffer sizes, lookup request and response
`default_nettype none

package switch_cfg_pkg;

   localparam int N_PORTS         = 6;
   localparam int FDB_ENTRIES     = 16;
   localparam int FDB_IDX_W       = 4;
   localparam int FRAME_MAX_BYTES = 64;
   localparam int BUF_ADDR_W      = 6;

   typedef logic [2:0]         port_idx_t;
   typedef logic [N_PORTS-1:0] port_vec_t;   // one bit per port

   // lookup request from one input buffer
   typedef struct packed {
      logic                     valid;
      eth_frame_pkg::mac_addr_t src_mac;
      eth_frame_pkg::mac_addr_t dst_mac;
   } fdb_req_t;

   typedef struct packed {
      logic      done;   // one cycle strobe
      logic      hit;
      port_idx_t port;
   } fdb_resp_t;

endpackage

`default_nettype wire

// ==== verilog/switch_top.sv ====
// six-port store-and-forward switch top: receive, buffer, lookup, crossbar and transmit
`timescale 1ns/1ps
`default_nettype none

module switch_top
(
   input  wire                                                       clk,
   input  wire                                                       rst_n_i,
   input  wire eth_frame_pkg::line_rx_t [switch_cfg_pkg::N_PORTS-1:0] rx_i,
   output eth_frame_pkg::line_tx_t [switch_cfg_pkg::N_PORTS-1:0]      tx_o
);

   import switch_cfg_pkg::*;
   import eth_frame_pkg::*;

   byte_strm_t [N_PORTS-1:0] rx_byte;
   byte_strm_t [N_PORTS-1:0] strm;
   fdb_req_t   [N_PORTS-1:0] fdb_req;
   fdb_resp_t  [N_PORTS-1:0] fdb_resp;
   port_vec_t  [N_PORTS-1:0] req_row;   // per input, one bit per output
   port_vec_t  [N_PORTS-1:0] req_col;   // per output, one bit per input
   port_vec_t  [N_PORTS-1:0] gnt_col;   // per output
   port_vec_t  [N_PORTS-1:0] gnt_row;   // per input
   logic       [N_PORTS-1:0] gnt_in;

   fdb_table u_fdb (.clk(clk), .rst_n_i(rst_n_i), .req_i(fdb_req), .resp_o(fdb_resp));

   for (genvar p = 0; p < N_PORTS; p++)
   begin : g_port
      nibble_rx u_rx (.clk(clk), .rst_n_i(rst_n_i), .rx_i(rx_i[p]), .byte_o(rx_byte[p]));

      ingress_buffer u_ibuf (
         .clk(clk), .rst_n_i(rst_n_i), .port_id_i(port_idx_t'(p)), .byte_i(rx_byte[p]),
         .fdb_req_o(fdb_req[p]), .fdb_resp_i(fdb_resp[p]), .req_o(req_row[p]),
         .gnt_i(gnt_in[p]), .strm_o(strm[p]));

      egress_port u_egr (
         .clk(clk), .rst_n_i(rst_n_i), .req_i(req_col[p]), .strm_i(strm),
         .gnt_o(gnt_col[p]), .tx_o(tx_o[p]));

      assign gnt_in[p] = |gnt_row[p];   // at most one output grants an input

      for (genvar q = 0; q < N_PORTS; q++)
      begin : g_xpose
         assign req_col[p][q] = req_row[q][p];
         assign gnt_row[p][q] = gnt_col[q][p];
      end
   end

endmodule

`default_nettype wire
